// File: hw/dmm_consts.svh
/*
  dmm front end constants
  chip-select codes, operating modes, register map and spi frame sizes
*/

`ifndef DMM_CONSTS_SVH
`define DMM_CONSTS_SVH

// chip-select vector codes, one per device on the shared bus
`define SPI_CS_VEC_DEASSERT     3'd0
`define SPI_CS_VEC_FPGA0        3'd1
`define SPI_CS_VEC_4094         3'd2
`define SPI_CS_VEC_INVERT_DAC   3'd3
`define SPI_CS_VEC_MDAC1        3'd4

// operating modes, low bits of cr
`define MODE_DIRECT             3'd0    // register control of every pin
`define MODE_SA_MOCK            3'd6    // sequencer with mock adc

// register addresses, 7 bit
`define REG_STATUS              7'd0    // read only
`define REG_CR                  7'd1
`define REG_DIRECT              7'd2
`define REG_4094_OE             7'd3
`define REG_SA_PRECHARGE        7'd4
`define REG_SA_SEQ_N            7'd5
`define REG_SA_SEQ0             7'd6
`define REG_SA_SEQ1             7'd7
`define REG_SA_SEQ2             7'd8
`define REG_SA_SEQ3             7'd9
`define REG_ADC_APERTURE        7'd10

`define STATUS_MAGIC            8'hAA

// spi frame, write flag + addr then data
`define SPI_ADDR_BITS           8
`define SPI_DATA_BITS           32

`endif

// File: hw/dmm_pkg.sv
/*
  dmm front end types
  register words, clock counts, sequence steps and the analog pin bundle
*/

`default_nettype none

package dmm_pkg;

  typedef logic [31:0] reg32_t;     // one spi register
  typedef logic [23:0] count24_t;   // clk counts, precharge and aperture
  typedef logic [2:0]  cs_vec_t;    // chip-select code
  typedef logic [2:0]  mode_t;      // alternate function select
  typedef logic [1:0]  seq_idx_t;   // step index, up to 4 steps

  // one sequencer step, low 6 bits of a seq register
  typedef struct packed {
    logic [3:0] azmux;
    logic [1:0] pc_sw;
  } seq_entry_t;

  typedef struct packed {
    logic [2:0]           seq_n;      // 1..4 steps, 0 acts as 1
    seq_entry_t [3:0]     seq;
    count24_t             precharge;
  } seq_cfg_t;

  // pin bundle, msb first, leds lsb is direct reg bit 0
  typedef struct packed {
    logic       spi_interrupt;
    logic       cmpr_latch;
    logic       sigmux;
    logic       rstmux;
    logic [1:0] refmux;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } af_pins_t;

  typedef enum logic [1:0] {
    IDLE,
    PRECHARGE,
    SAMPLE
  } sa_state_t;

endpackage

`default_nettype wire

// File: hw/spi_cs_decode.sv
/*
  spi chip-select decode
  one shared bus for fpga, 4094, inverting dac and isolated mdac
  global clk/mosi parked high while the fpga itself is addressed
*/

`timescale 1ns/1ps
`default_nettype none

`include "dmm_consts.svh"

module spi_cs_decode
  import dmm_pkg::*;
(
  input  cs_vec_t cs_vec_i,
  input  logic    sck_i,
  input  logic    sdi_i,

  output logic    fpga_cs_n_o,
  output logic    spi_glb_clk_o,
  output logic    spi_glb_mosi_o,
  output logic    spi_4094_strobe_o,
  output logic    spi_invert_dac_ss_o,
  output logic    spi_invert_dac_clk_o,
  output logic    spi_invert_dac_data_o,
  output logic    spi_iso_cs_o
);

  logic sel_fpga;

  assign sel_fpga = (cs_vec_i == `SPI_CS_VEC_FPGA0);

  // register set select, active lo
  assign fpga_cs_n_o = ~sel_fpga;

  // silence the shared lines during register access
  assign spi_glb_clk_o  = sel_fpga ? 1'b1 : sck_i;     // park hi
  assign spi_glb_mosi_o = sel_fpga ? 1'b1 : sdi_i;     // park hi

  assign spi_4094_strobe_o   = (cs_vec_i == `SPI_CS_VEC_4094);            // active hi
  assign spi_invert_dac_ss_o = ~(cs_vec_i == `SPI_CS_VEC_INVERT_DAC);     // active lo
  assign spi_iso_cs_o        = ~(cs_vec_i == `SPI_CS_VEC_MDAC1);          // active lo

  // dac sits on the global lines
  assign spi_invert_dac_data_o = spi_glb_mosi_o;
  assign spi_invert_dac_clk_o  = spi_glb_clk_o;

endmodule

`default_nettype wire

// File: hw/register_set.sv
/*
  spi register set
  40 bit frames, write flag + 7 bit addr then 32 bit data, msb first
  holds the configuration and assembles the status word
*/

`timescale 1ns/1ps
`default_nettype none

`include "dmm_consts.svh"

module register_set
  import dmm_pkg::*;
(
  input  logic       sck_i,
  input  logic       arst_n_i,
  input  logic       cs_n_i,
  input  logic       sdi_i,
  input  logic [3:0] hw_flags_i,
  input  seq_idx_t   sample_idx_last_i,
  input  logic       first_last_i,

  output logic       sdo_o,
  output mode_t      mode_o,
  output af_pins_t   direct_o,
  output logic       oe_4094_o,
  output seq_cfg_t   seq_cfg_o,
  output count24_t   aperture_o
);

  localparam int FRAME_BITS = `SPI_ADDR_BITS + `SPI_DATA_BITS;

  logic [5:0] bit_cnt;      // rising edges seen this frame
  reg32_t     sr_in;
  logic [7:0] addr_q;       // bit 7 write flag
  reg32_t     sr_out;
  logic       frame_rst_n;
  logic       wr_en;
  reg32_t     wdata;
  reg32_t     rdata;
  reg32_t     status;

  // writable registers
  reg32_t reg_cr;
  reg32_t reg_direct;
  reg32_t reg_4094_oe;
  reg32_t reg_sa_precharge;
  reg32_t reg_sa_seq_n;
  reg32_t reg_sa_seq [4];
  reg32_t reg_adc_aperture;

  // frame state clears whenever cs is released
  assign frame_rst_n = arst_n_i & ~cs_n_i;

  ////////////////////////////////////////////////////////////
  // shift in, rising sck

  always_ff @(posedge sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n) begin
      bit_cnt <= '0;
      sr_in   <= '0;
      addr_q  <= '0;
    end else begin
      sr_in <= {sr_in[30:0], sdi_i};
      if (bit_cnt != 6'(FRAME_BITS))
        bit_cnt <= bit_cnt + 6'd1;               // hold at end of frame
      if (bit_cnt == 6'(`SPI_ADDR_BITS - 1))
        addr_q <= {sr_in[6:0], sdi_i};          // flag + addr complete
    end
  end

  assign wdata = {sr_in[30:0], sdi_i};
  assign wr_en = addr_q[7] && (bit_cnt == 6'(FRAME_BITS - 1));   // 40th edge

  always_ff @(posedge sck_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_cr           <= '0;
      reg_direct       <= '0;
      reg_4094_oe      <= '0;
      reg_sa_precharge <= '0;
      reg_sa_seq_n     <= '0;
      reg_sa_seq[0]    <= '0;
      reg_sa_seq[1]    <= '0;
      reg_sa_seq[2]    <= '0;
      reg_sa_seq[3]    <= '0;
      reg_adc_aperture <= '0;
    end else if (wr_en) begin
      case (addr_q[6:0])
        `REG_CR:           reg_cr           <= wdata;
        `REG_DIRECT:       reg_direct       <= wdata;
        `REG_4094_OE:      reg_4094_oe      <= wdata;
        `REG_SA_PRECHARGE: reg_sa_precharge <= wdata;
        `REG_SA_SEQ_N:     reg_sa_seq_n     <= wdata;
        `REG_SA_SEQ0:      reg_sa_seq[0]    <= wdata;
        `REG_SA_SEQ1:      reg_sa_seq[1]    <= wdata;
        `REG_SA_SEQ2:      reg_sa_seq[2]    <= wdata;
        `REG_SA_SEQ3:      reg_sa_seq[3]    <= wdata;
        `REG_ADC_APERTURE: reg_adc_aperture <= wdata;
        default: ;                              // status, unknown
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback

  // quasi-static inputs from the clk domain
  assign status = {9'b0, reg_sa_seq_n[2:0],        // 22:20
                   1'b0, first_last_i,             // 18
                   sample_idx_last_i,              // 17:16
                   4'b0, hw_flags_i,               // 11:8
                   `STATUS_MAGIC};

  always_comb begin
    case (addr_q[6:0])
      `REG_STATUS:       rdata = status;
      `REG_CR:           rdata = reg_cr;
      `REG_DIRECT:       rdata = reg_direct;
      `REG_4094_OE:      rdata = reg_4094_oe;
      `REG_SA_PRECHARGE: rdata = reg_sa_precharge;
      `REG_SA_SEQ_N:     rdata = reg_sa_seq_n;
      `REG_SA_SEQ0:      rdata = reg_sa_seq[0];
      `REG_SA_SEQ1:      rdata = reg_sa_seq[1];
      `REG_SA_SEQ2:      rdata = reg_sa_seq[2];
      `REG_SA_SEQ3:      rdata = reg_sa_seq[3];
      `REG_ADC_APERTURE: rdata = reg_adc_aperture;
      default:           rdata = '0;
    endcase
  end

  // shift out, falling sck. load right after the address byte
  always_ff @(negedge sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n)
      sr_out <= '0;
    else if (bit_cnt == 6'(`SPI_ADDR_BITS) && !addr_q[7])
      sr_out <= rdata;
    else
      sr_out <= {sr_out[30:0], 1'b0};
  end

  assign sdo_o = sr_out[31];    // held 0 while deselected

  ////////////////////////////////////////////////////////////
  // config out

  assign mode_o     = reg_cr[2:0];
  assign direct_o   = af_pins_t'(reg_direct[23:0]);
  assign oe_4094_o  = reg_4094_oe[0];
  assign aperture_o = reg_adc_aperture[23:0];

  assign seq_cfg_o.seq_n     = reg_sa_seq_n[2:0];
  assign seq_cfg_o.seq[0]    = seq_entry_t'(reg_sa_seq[0][5:0]);
  assign seq_cfg_o.seq[1]    = seq_entry_t'(reg_sa_seq[1][5:0]);
  assign seq_cfg_o.seq[2]    = seq_entry_t'(reg_sa_seq[2][5:0]);
  assign seq_cfg_o.seq[3]    = seq_entry_t'(reg_sa_seq[3][5:0]);
  assign seq_cfg_o.precharge = reg_sa_precharge[23:0];

endmodule

`default_nettype wire

// File: hw/adc_mock.sv
/*
  mock adc
  counts the aperture once released from reset, then pulses measure valid
*/

`timescale 1ns/1ps
`default_nettype none

module adc_mock
  import dmm_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     reset_n_i,       // held lo by the sequencer outside sample
  input  count24_t aperture_i,

  output logic     measure_valid_o
);

  count24_t count;

  // one cycle pulse at the end of the aperture
  assign measure_valid_o = reset_n_i && (count == aperture_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i)
      count <= '0;
    else if (!reset_n_i || measure_valid_o)
      count <= '0;                       // restart
    else
      count <= count + 24'd1;
  end

endmodule

`default_nettype wire

// File: hw/sequence_acquisition.sv
/*
  sequence acquisition
  alternates precharge and sample over up to four azmux/pc_sw steps
  paired with the mock adc, runs while the trig input is high
*/

`timescale 1ns/1ps
`default_nettype none

module sequence_acquisition
  import dmm_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     sa_trig_i,
  input  logic     measure_valid_i,
  input  seq_cfg_t cfg_i,

  output logic     adc_reset_n_o,
  output af_pins_t pins_o,
  output seq_idx_t sample_idx_last_o,
  output logic     first_last_o
);

  logic [1:0] trig_sync;
  logic       trig;
  sa_state_t  state;
  count24_t   pc_cnt;       // cycles spent in precharge
  seq_idx_t   idx;
  seq_entry_t cur;
  logic [2:0] idx_nxt;
  logic       wrap;
  logic       sample_done;

  ////////////////////////////////////////////////////////////
  // trig, async from the mcu

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i)
      trig_sync <= '0;
    else
      trig_sync <= {trig_sync[0], sa_trig_i};
  end

  assign trig = trig_sync[1];

  assign cur         = cfg_i.seq[idx];
  assign idx_nxt     = {1'b0, idx} + 3'd1;
  assign wrap        = (idx_nxt >= cfg_i.seq_n);     // seq_n 0 always wraps, same as 1
  assign sample_done = trig && (state == SAMPLE) && measure_valid_i;

  ////////////////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state  <= IDLE;
      pc_cnt <= '0;
      idx    <= '0;
    end else if (!trig) begin
      state  <= IDLE;
      pc_cnt <= '0;
      idx    <= '0;
    end else begin
      case (state)
        IDLE: begin
          state  <= PRECHARGE;
          pc_cnt <= 24'd1;
        end
        PRECHARGE: begin
          if (pc_cnt >= cfg_i.precharge)
            state <= SAMPLE;                 // exactly precharge cycles
          else
            pc_cnt <= pc_cnt + 24'd1;
        end
        SAMPLE: begin
          if (sample_done) begin             // adc finished
            state  <= PRECHARGE;
            pc_cnt <= 24'd1;
            idx    <= wrap ? 2'd0 : idx_nxt[1:0];
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // last completed step, for the status word
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_idx_last_o <= '0;
      first_last_o      <= 1'b0;
    end else if (sample_done) begin
      sample_idx_last_o <= idx;
      first_last_o      <= (idx == 2'd0);
    end
  end

  ////////////////////////////////////////////////////////////
  // pin bundle

  assign adc_reset_n_o = (state == SAMPLE);  // adc runs only in sample

  always_comb begin
    pins_o = '0;                             // refmux, sigmux etc stay lo
    pins_o.monitor = {3'b000, idx,
                      state == SAMPLE,
                      state == PRECHARGE,
                      measure_valid_i};
    if (state != IDLE) begin
      pins_o.azmux = cur.azmux;
      pins_o.leds  = 4'b0001 << idx;         // one-hot step
    end
    if (state == SAMPLE)
      pins_o.pc_sw = cur.pc_sw;              // 0 during precharge
  end

endmodule

`default_nettype wire

// File: hw/af_output_select.sv
/*
  alternate function select
  picks the analog pin bundle for the operating mode, zero otherwise
*/

`timescale 1ns/1ps
`default_nettype none

`include "dmm_consts.svh"

module af_output_select
  import dmm_pkg::*;
(
  input  mode_t    mode_i,
  input  af_pins_t direct_i,
  input  af_pins_t sa_pins_i,

  output af_pins_t pins_o
);

  always_comb begin
    case (mode_i)
      `MODE_DIRECT:  pins_o = direct_i;     // every pin from the register
      `MODE_SA_MOCK: pins_o = sa_pins_i;    // sequencer + mock adc
      default:       pins_o = '0;           // unused modes park lo
    endcase
  end

endmodule

`default_nettype wire

// File: hw/dmm_top.sv
/*
  dmm front end fpga top
  spi cs decode, register set, sequencer with mock adc and pin mux
*/

`timescale 1ns/1ps
`default_nettype none

module dmm_top
  import dmm_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,

  // spi
  input  logic       sck_i,
  input  logic       sdi_i,
  input  cs_vec_t    spi_cs_vec_i,
  output logic       sdo_o,

  input  logic [3:0] hw_flags_i,
  input  logic       adc_cmpr_i,      // no user without the modulator
  input  logic       sa_trig_i,

  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,

  // shared bus and device selects
  output logic       spi_glb_mosi_o,
  output logic       spi_glb_clk_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_4094_oe_o,
  output logic       spi_iso_cs_o,
  output logic       spi_invert_dac_data_o,
  output logic       spi_invert_dac_clk_o,
  output logic       spi_invert_dac_ss_o,

  // analog switches
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [1:0] adc_refmux_o,
  output logic       adc_sigmux_o,
  output logic       adc_rstmux_o,
  output logic       adc_cmpr_latch_ctl_o,
  output logic       spi_interrupt_ctl_o
);

  logic     fpga_cs_n;
  mode_t    mode;
  af_pins_t direct_pins;
  af_pins_t sa_pins;
  af_pins_t pins;
  seq_cfg_t seq_cfg;
  count24_t aperture;
  seq_idx_t sample_idx_last;
  logic     first_last;
  logic     adc_reset_n;
  logic     measure_valid;

  ////////////////////////////////////////////////////////////
  // spi

  spi_cs_decode spi_cs_decode_i (
    .cs_vec_i              (spi_cs_vec_i),
    .sck_i                 (sck_i),
    .sdi_i                 (sdi_i),
    .fpga_cs_n_o           (fpga_cs_n),
    .spi_glb_clk_o         (spi_glb_clk_o),
    .spi_glb_mosi_o        (spi_glb_mosi_o),
    .spi_4094_strobe_o     (spi_4094_strobe_o),
    .spi_invert_dac_ss_o   (spi_invert_dac_ss_o),
    .spi_invert_dac_clk_o  (spi_invert_dac_clk_o),
    .spi_invert_dac_data_o (spi_invert_dac_data_o),
    .spi_iso_cs_o          (spi_iso_cs_o)
  );

  register_set register_set_i (
    .sck_i             (sck_i),           // host clock domain
    .arst_n_i          (arst_n_i),
    .cs_n_i            (fpga_cs_n),
    .sdi_i             (sdi_i),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .first_last_i      (first_last),
    .sdo_o             (sdo_o),
    .mode_o            (mode),
    .direct_o          (direct_pins),
    .oe_4094_o         (spi_4094_oe_o),
    .seq_cfg_o         (seq_cfg),
    .aperture_o        (aperture)
  );

  ////////////////////////////////////////////////////////////
  // acquisition, mode 6

  adc_mock adc_mock_i (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .reset_n_i       (adc_reset_n),
    .aperture_i      (aperture),
    .measure_valid_o (measure_valid)
  );

  sequence_acquisition sequence_acquisition_i (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .sa_trig_i         (sa_trig_i),
    .measure_valid_i   (measure_valid),   // fan-in from mock adc
    .cfg_i             (seq_cfg),
    .adc_reset_n_o     (adc_reset_n),
    .pins_o            (sa_pins),
    .sample_idx_last_o (sample_idx_last),
    .first_last_o      (first_last)
  );

  af_output_select af_output_select_i (
    .mode_i    (mode),
    .direct_i  (direct_pins),
    .sa_pins_i (sa_pins),
    .pins_o    (pins)
  );

  // bundle onto pins
  assign spi_interrupt_ctl_o  = pins.spi_interrupt;
  assign adc_cmpr_latch_ctl_o = pins.cmpr_latch;
  assign adc_sigmux_o         = pins.sigmux;
  assign adc_rstmux_o         = pins.rstmux;
  assign adc_refmux_o         = pins.refmux;
  assign azmux_o              = pins.azmux;
  assign pc_sw_o              = pins.pc_sw;
  assign monitor_o            = pins.monitor;
  assign leds_o               = pins.leds;

endmodule

`default_nettype wire

// File: testbench/tb_dmm_top.sv
/*
  testbench for the dmm front end top level
  bit-banged spi register access, cs decode table, direct mode pins,
  mode 6 sequencing with the mock adc and last-sample status
*/

`timescale 1ns/1ps
`default_nettype none

`include "dmm_consts.svh"

module tb_dmm_top
  import dmm_pkg::*;
;

  localparam int N_PULSES      = 7;
  localparam int PRECHARGE_CYC = 3;
  localparam int APERTURE_CYC  = 4;
  localparam int TIMEOUT_CYC   = 100;   // per wait loop

  // expected cs decode levels for one code
  typedef struct packed {
    logic strobe;
    logic dac_ss_n;
    logic iso_cs_n;
    logic glb_hi;       // global clk and mosi parked
  } cs_exp_t;

  logic       clk;
  logic       arst_n_i;
  logic       sck_i;
  logic       sdi_i;
  cs_vec_t    spi_cs_vec_i;
  logic [3:0] hw_flags_i;
  logic       adc_cmpr_i;
  logic       sa_trig_i;

  logic       sdo_o;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic       spi_glb_mosi_o;
  logic       spi_glb_clk_o;
  logic       spi_4094_strobe_o;
  logic       spi_4094_oe_o;
  logic       spi_iso_cs_o;
  logic       spi_invert_dac_data_o;
  logic       spi_invert_dac_clk_o;
  logic       spi_invert_dac_ss_o;
  logic [1:0] pc_sw_o;
  logic [3:0] azmux_o;
  logic [1:0] adc_refmux_o;
  logic       adc_sigmux_o;
  logic       adc_rstmux_o;
  logic       adc_cmpr_latch_ctl_o;
  logic       spi_interrupt_ctl_o;

  af_pins_t   pins_obs;   // pins gathered back into a bundle

  // stimulus tables
  cs_exp_t    cs_tab [8];
  reg32_t     direct_in [5];
  reg32_t     oe_in [4];
  logic       oe_exp [4];
  seq_entry_t seq_tab [4];

  dmm_top dut_i (.*);

  assign pins_obs = {spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o, adc_sigmux_o,
                     adc_rstmux_o, adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o};

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_reg(input string name, input reg32_t exp, input reg32_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_pins(input string name, input af_pins_t exp, input af_pins_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_idx(input string name, input seq_idx_t exp, input seq_idx_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic next_edge();
    @(posedge clk);
    #1;                 // drive and sample clear of the edge
  endtask

  task automatic half_bit();
    repeat (2) next_edge();   // sck at clk/4
  endtask

  // one 40 bit frame with sdo captured while sck is low
  task automatic spi_frame(input logic wr, input logic [6:0] addr,
                           input reg32_t wdata, output reg32_t rdata);
    logic [39:0] frame;
    int          i;
    frame = {wr, addr, wdata};
    rdata = '0;
    spi_cs_vec_i = `SPI_CS_VEC_FPGA0;
    for (i = 39; i >= 0; i--) begin
      sdi_i = frame[i];
      half_bit();
      if (i < 32)
        rdata = {rdata[30:0], sdo_o};
      sck_i = 1'b1;
      half_bit();
      sck_i = 1'b0;
    end
    half_bit();
    spi_cs_vec_i = `SPI_CS_VEC_DEASSERT;
    sdi_i = 1'b0;
    half_bit();
  endtask

  task automatic reg_write(input logic [6:0] addr, input reg32_t data);
    reg32_t unused;
    spi_frame(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [6:0] addr, output reg32_t data);
    spi_frame(1'b0, addr, '0, data);
  endtask

  // status layout from the register map
  function automatic reg32_t status_word(input logic [3:0] flags, input logic [2:0] seq_n,
                                         input seq_idx_t idx, input logic first);
    reg32_t w;
    w        = '0;
    w[7:0]   = `STATUS_MAGIC;
    w[11:8]  = flags;
    w[17:16] = idx;
    w[18]    = first;
    w[22:20] = seq_n;
    return w;
  endfunction

  // sequencer bundle for one step in precharge or sample
  function automatic af_pins_t seq_pins(input seq_entry_t e, input seq_idx_t idx,
                                        input logic pc, input logic smp, input logic mv);
    af_pins_t p;
    p         = '0;
    p.azmux   = e.azmux;
    p.pc_sw   = smp ? e.pc_sw : 2'b00;
    p.monitor = {3'b000, idx, smp, pc, mv};
    p.leds    = 4'b0001 << idx;
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    int unsigned seed;
    int unsigned rnd;
    reg32_t      wr_val [11];
    reg32_t      rd;
    int          a;
    int          k;
    int          pulses;
    int          pc_run;
    int          smp_run;
    int          wait_cnt;
    seq_idx_t    step;
    seq_idx_t    last_idx;

    clk          = 1'b0;
    arst_n_i     = 1'b0;
    sck_i        = 1'b0;
    sdi_i        = 1'b0;
    spi_cs_vec_i = `SPI_CS_VEC_DEASSERT;
    hw_flags_i   = 4'h5;
    adc_cmpr_i   = 1'b0;
    sa_trig_i    = 1'b0;
    seed         = 32'h90b5;
    rnd          = $urandom(seed);

    // {strobe, dac_ss_n, iso_cs_n, glb_hi} per code
    cs_tab[0] = 4'b0110;
    cs_tab[1] = 4'b0111;
    cs_tab[2] = 4'b1110;
    cs_tab[3] = 4'b0010;
    cs_tab[4] = 4'b0100;
    cs_tab[5] = 4'b0110;
    cs_tab[6] = 4'b0110;
    cs_tab[7] = 4'b0110;

    direct_in[0] = 32'h0000_0001;      // led 0
    direct_in[1] = 32'h0080_0000;      // spi interrupt
    direct_in[2] = 32'hAB5A_5A5A;      // upper byte dropped
    direct_in[3] = 32'h00FF_FFFF;
    direct_in[4] = $urandom;

    oe_in[0]  = 32'd1;
    oe_exp[0] = 1'b1;
    oe_in[1]  = 32'd0;
    oe_exp[1] = 1'b0;
    oe_in[2]  = 32'd3;
    oe_exp[2] = 1'b1;
    oe_in[3]  = 32'd2;
    oe_exp[3] = 1'b0;

    seq_tab[0] = {4'h1, 2'd1};
    seq_tab[1] = {4'h2, 2'd2};
    seq_tab[2] = {4'h4, 2'd3};
    seq_tab[3] = {4'h8, 2'd0};         // unused with 3 steps

    repeat (2) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    next_edge();

    // reset state is mode 0 with direct 0
    check_pins("reset pins", '0, pins_obs);
    check_bit("reset 4094 oe", 1'b0, spi_4094_oe_o);

    // register readback
    for (a = `REG_CR; a <= `REG_ADC_APERTURE; a++) begin
      wr_val[a] = $urandom;
      reg_write(7'(a), wr_val[a]);
    end
    reg_write(7'd11, $urandom);        // unknown addr is ignored
    reg_write(7'd127, $urandom);
    reg_write(`REG_STATUS, $urandom);  // read only
    for (a = `REG_CR; a <= `REG_ADC_APERTURE; a++) begin
      reg_read(7'(a), rd);
      check_reg($sformatf("readback addr %0d", a), wr_val[a], rd);
    end
    reg_read(7'd11, rd);
    check_reg("unknown addr 11", '0, rd);
    reg_read(7'd127, rd);
    check_reg("unknown addr 127", '0, rd);

    // status word
    reg_read(`REG_STATUS, rd);
    check_reg("status random seq_n",
              status_word(hw_flags_i, wr_val[`REG_SA_SEQ_N][2:0], 2'd0, 1'b0), rd);
    hw_flags_i = 4'hC;
    reg_write(`REG_SA_SEQ_N, 32'd4);
    reg_read(`REG_STATUS, rd);
    check_reg("status seq_n 4", status_word(4'hC, 3'd4, 2'd0, 1'b0), rd);

    // cs decode with sck and sdi low
    for (k = 0; k < 8; k++) begin
      spi_cs_vec_i = cs_vec_t'(k);
      next_edge();
      check_bit($sformatf("cs %0d 4094 strobe", k), cs_tab[k].strobe, spi_4094_strobe_o);
      check_bit($sformatf("cs %0d dac ss", k), cs_tab[k].dac_ss_n, spi_invert_dac_ss_o);
      check_bit($sformatf("cs %0d iso cs", k), cs_tab[k].iso_cs_n, spi_iso_cs_o);
      check_bit($sformatf("cs %0d glb clk", k), cs_tab[k].glb_hi, spi_glb_clk_o);
      check_bit($sformatf("cs %0d glb mosi", k), cs_tab[k].glb_hi, spi_glb_mosi_o);
      check_bit($sformatf("cs %0d dac clk", k), cs_tab[k].glb_hi, spi_invert_dac_clk_o);
      check_bit($sformatf("cs %0d dac data", k), cs_tab[k].glb_hi, spi_invert_dac_data_o);
      if (k != 1)
        check_bit($sformatf("cs %0d sdo", k), 1'b0, sdo_o);
    end
    spi_cs_vec_i = `SPI_CS_VEC_DEASSERT;
    next_edge();

    ////////////////////////////////////////////////////////////
    // direct mode and 4094 oe

    reg_write(`REG_CR, {29'b0, `MODE_DIRECT});
    for (k = 0; k < 5; k++) begin
      reg_write(`REG_DIRECT, direct_in[k]);
      check_pins($sformatf("direct %0d", k), af_pins_t'(direct_in[k][23:0]), pins_obs);
    end
    reg_write(`REG_CR, 32'd3);
    check_pins("mode 3 pins", '0, pins_obs);
    for (k = 0; k < 4; k++) begin
      reg_write(`REG_4094_OE, oe_in[k]);
      check_bit($sformatf("4094 oe %0d", k), oe_exp[k], spi_4094_oe_o);
    end

    ////////////////////////////////////////////////////////////
    // mode 6 sequencing

    reg_write(`REG_SA_SEQ_N, 32'd3);
    for (k = 0; k < 4; k++)
      reg_write(7'(`REG_SA_SEQ0 + k), 32'(seq_tab[k]));
    reg_write(`REG_SA_PRECHARGE, 32'(PRECHARGE_CYC));
    reg_write(`REG_ADC_APERTURE, 32'(APERTURE_CYC));
    reg_write(`REG_CR, {29'b0, `MODE_SA_MOCK});
    check_pins("mode 6 idle", '0, pins_obs);

    pulses   = 0;
    pc_run   = 0;
    smp_run  = 0;
    wait_cnt = 0;
    sa_trig_i = 1'b1;
    while (pulses < N_PULSES) begin
      next_edge();
      wait_cnt++;
      if (wait_cnt > TIMEOUT_CYC)
        abort_run("timeout while waiting for a measure valid pulse in mode 6");
      step = seq_idx_t'(pulses % 3);
      if (monitor_o[1]) begin
        pc_run++;
        check_pins("precharge pins", seq_pins(seq_tab[step], step, 1'b1, 1'b0, 1'b0),
                   pins_obs);
      end else if (pc_run != 0) begin
        check_reg("precharge length", PRECHARGE_CYC, pc_run);
        pc_run = 0;
      end
      if (monitor_o[2])
        smp_run++;
      if (monitor_o[0]) begin        // end of sample
        check_pins($sformatf("pulse %0d pins", pulses),
                   seq_pins(seq_tab[step], step, 1'b0, 1'b1, 1'b1), pins_obs);
        check_reg("sample length", APERTURE_CYC + 1, smp_run);
        smp_run  = 0;
        wait_cnt = 0;
        pulses++;
      end else if (monitor_o[2]) begin
        check_pins("sample pins", seq_pins(seq_tab[step], step, 1'b0, 1'b1, 1'b0),
                   pins_obs);
      end
    end

    ////////////////////////////////////////////////////////////
    // back to idle then last sample in status

    sa_trig_i = 1'b0;
    wait_cnt  = 0;
    next_edge();
    while (monitor_o[2:1] != 2'b00) begin
      if (monitor_o[0])
        pulses++;                    // a late sample still counts
      wait_cnt++;
      if (wait_cnt > TIMEOUT_CYC)
        abort_run("timeout while waiting for the sequencer to return to idle");
      next_edge();
    end
    check_pins("idle after trig low", '0, pins_obs);

    last_idx = seq_idx_t'((pulses - 1) % 3);
    reg_read(`REG_STATUS, rd);
    check_idx("status sample_idx_last", last_idx, rd[17:16]);
    check_bit("status first_last", last_idx == 2'd0, rd[18]);
    check_reg("status after sequence",
              status_word(4'hC, 3'd3, last_idx, last_idx == 2'd0), rd);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/dmm_pkg.sv
hw/spi_cs_decode.sv
hw/register_set.sv
hw/adc_mock.sv
hw/sequence_acquisition.sv
hw/af_output_select.sv
hw/dmm_top.sv
testbench/tb_dmm_top.sv
